/* logic/mbPkg.sv */
`default_nettype none

package mbPkg;

   typedef logic [31:0] dataWord;
   typedef logic [4:0]  regAddr;

   // Register form, second operand from rb
   typedef struct packed {
      logic [5:0]  opcode;
      regAddr      rd;
      regAddr      ra;
      regAddr      rb;
      logic [10:0] func;
   } instRegForm;

   // Immediate form, sign-extended 16-bit operand
   typedef struct packed {
      logic [5:0]  opcode;
      regAddr      rd;
      regAddr      ra;
      logic [15:0] imm;
   } instImmForm;

   typedef union packed {
      instRegForm rForm;
      instImmForm iForm;
   } instWord;

   typedef enum logic [2:0] {
      selAdd    = 3'd0,
      selLogic  = 3'd1,
      selShift  = 3'd2,
      selMove   = 3'd3,
      selBarrel = 3'd4,
      selStore  = 3'd5
   } aluSel;

   localparam logic [5:0] opAdd    = 6'h00;
   localparam logic [5:0] opRsub   = 6'h01;
   localparam logic [5:0] opAddc   = 6'h02;
   localparam logic [5:0] opRsubc  = 6'h03;
   localparam logic [5:0] opAddi   = 6'h08;
   localparam logic [5:0] opRsubi  = 6'h09;
   localparam logic [5:0] opAddic  = 6'h0A;
   localparam logic [5:0] opRsubic = 6'h0B;
   localparam logic [5:0] opBarrel = 6'h11; // Immediate form sets bit 3
   localparam logic [5:0] opOr     = 6'h20;
   localparam logic [5:0] opAnd    = 6'h21;
   localparam logic [5:0] opXor    = 6'h22;
   localparam logic [5:0] opAndn   = 6'h23;
   localparam logic [5:0] opShift  = 6'h24;
   localparam logic [5:0] opMsr    = 6'h25;
   localparam logic [5:0] opSb     = 6'h30;
   localparam logic [5:0] opSh     = 6'h31;
   localparam logic [5:0] opSw     = 6'h32;

   localparam logic [7:0] msrVersion = 8'h3A;

   // Status read-back, C appears twice
   function automatic dataWord msrWord(input logic c, input logic bip, input logic ie,
                                       input logic be);
      return {c, 15'd0, msrVersion, 4'd0, bip, c, ie, be};
   endfunction

endpackage

`default_nettype wire

/* logic/execBus.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded instruction handed from decode to execute
interface execBus import mbPkg::*; ();

   logic        valid;
   dataWord     opA;        // Already inverted for reverse subtract
   dataWord     opB;
   logic        carryIn;
   aluSel       sel;
   logic [5:0]  opcode;
   logic [15:0] imm;        // Raw low half of the instruction
   regAddr      rd;
   dataWord     storeData;

   modport dec (
      output valid,
      output opA,
      output opB,
      output carryIn,
      output sel,
      output opcode,
      output imm,
      output rd,
      output storeData
   );

   modport exe (
      input valid,
      input opA,
      input opB,
      input carryIn,
      input sel,
      input opcode,
      input imm,
      input rd,
      input storeData
   );

endinterface

`default_nettype wire

/* logic/instDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecode import mbPkg::*; (
   input  logic    gclk,
   input  logic    rstN,
   input  instWord instr,
   input  logic    instrValid,
   input  logic    wbValid,
   input  regAddr  wbRd,
   input  dataWord wbData,
   input  logic    exValid,
   input  regAddr  exRd,
   input  aluSel   exSel,
   input  dataWord exResult,
   execBus.dec     bus
);

   dataWord    regFile [32];
   instWord    instReg;
   logic       validReg;
   logic [5:0] opBase;
   logic       isImm;
   logic       isSub;
   aluSel      decSel;
   dataWord    raVal;
   dataWord    rbVal;
   dataWord    rdVal;
   dataWord    immExt;

   // Execute stage wins over write-back, r0 is hardwired
   function automatic dataWord readOperand(input regAddr idx);
      dataWord val;
      if (idx == '0)
         val = '0;
      else if (exValid && exSel != selStore && exRd == idx)
         val = exResult;
      else if (wbValid && wbRd == idx)
         val = wbData;
      else
         val = regFile[idx];
      return val;
   endfunction

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         validReg <= 1'b0;
         for (int i = 0; i < 32; i++)
            regFile[i] <= '0;
      end else begin
         validReg <= instrValid;
         if (wbValid && wbRd != '0)
            regFile[wbRd] <= wbData;
      end
   end

   always_ff @(posedge gclk) begin
      if (instrValid)
         instReg <= instr;
   end

   assign isImm  = instReg.rForm.opcode[3];
   assign opBase = instReg.rForm.opcode & 6'b110111; // Fold immediate forms

   always_comb begin
      case (opBase)
         opOr, opAnd, opXor, opAndn: decSel = selLogic;
         opShift:                    decSel = selShift;
         opMsr:                      decSel = selMove;
         opBarrel:                   decSel = selBarrel;
         opSb, opSh, opSw:           decSel = selStore;
         default:                    decSel = selAdd; // Add and rsub family
      endcase
   end

   assign isSub = (decSel == selAdd) && instReg.rForm.opcode[0];

   always_comb begin
      raVal = readOperand(instReg.rForm.ra);
      rbVal = readOperand(instReg.rForm.rb);
      rdVal = readOperand(instReg.rForm.rd); // Store source
   end

   assign immExt = {{16{instReg.iForm.imm[15]}}, instReg.iForm.imm};

   assign bus.valid     = validReg;
   assign bus.opA       = isSub ? ~raVal : raVal;
   assign bus.opB       = isImm ? immExt : rbVal;
   assign bus.carryIn   = isSub; // Carry forms take C in execute
   assign bus.sel       = decSel;
   assign bus.opcode    = instReg.iForm.opcode;
   assign bus.imm       = instReg.iForm.imm;
   assign bus.rd        = instReg.iForm.rd;
   assign bus.storeData = rdVal;

endmodule

`default_nettype wire

/* logic/execUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module execUnit import mbPkg::*; #(
   parameter bit barrelShift = 1'b1
) (
   input  logic       gclk,
   input  logic       rstN,
   execBus.exe        bus,
   output logic       exValid,
   output dataWord    exResult,
   output regAddr     exRd,
   output aluSel      exSel,
   output logic [3:0] exAddrLow,   // Store size in [3:2], byte offset in [1:0]
   output dataWord    exStoreData,
   output logic       msrC,
   output logic       msrIe
);

   logic    msrBip;
   logic    msrBe;
   logic    carry;
   logic    addCarry;
   dataWord addRes;
   dataWord logicRes;
   dataWord shiftRes;
   logic    shiftCarry;
   logic    isMts;
   dataWord moveRes;
   dataWord barrelRes;
   dataWord result;
   logic    nextC;
   logic    nextIe;
   logic    nextBip;
   logic    nextBe;

   // Carry forms use the live C
   assign carry = (bus.sel == selAdd && bus.opcode[1]) ? msrC : bus.carryIn;
   assign {addCarry, addRes} = {1'b0, bus.opA} + {1'b0, bus.opB} + {32'd0, carry};

   always_comb begin
      case (bus.opcode[1:0])
         2'b00:   logicRes = bus.opA | bus.opB;
         2'b01:   logicRes = bus.opA & bus.opB;
         2'b10:   logicRes = bus.opA ^ bus.opB;
         default: logicRes = bus.opA & ~bus.opB; // andn
      endcase
   end

   // Single-bit right shifts push bit 0 into C
   always_comb begin
      shiftCarry = bus.opA[0];
      case (bus.imm[6:5])
         2'b00:   shiftRes = {bus.opA[31], bus.opA[31:1]};
         2'b01:   shiftRes = {msrC, bus.opA[31:1]};
         2'b10:   shiftRes = {1'b0, bus.opA[31:1]};
         default: begin
            shiftCarry = msrC; // Sign extension keeps C
            if (bus.imm[0])
               shiftRes = {{16{bus.opA[15]}}, bus.opA[15:0]};
            else
               shiftRes = {{24{bus.opA[7]}}, bus.opA[7:0]};
         end
      endcase
   end

   assign isMts   = bus.imm[14];
   assign moveRes = isMts ? bus.opA : msrWord(msrC, msrBip, msrIe, msrBe);

   always_comb begin
      barrelRes = '0; // Without the shifter barrel ops write zero
      if (barrelShift) begin
         case (bus.imm[10:9])
            2'b00:   barrelRes = bus.opA >> bus.opB[4:0];
            2'b01:   barrelRes = dataWord'($signed(bus.opA) >>> bus.opB[4:0]);
            2'b10:   barrelRes = bus.opA << bus.opB[4:0];
            default: barrelRes = '0;
         endcase
      end
   end

   always_comb begin
      case (bus.sel)
         selAdd:    result = addRes;
         selLogic:  result = logicRes;
         selShift:  result = shiftRes;
         selMove:   result = moveRes;
         selBarrel: result = barrelRes;
         selStore:  result = addRes; // Effective address
         default:   result = '0;
      endcase
   end

   // Next status bits
   always_comb begin
      nextC   = msrC;
      nextIe  = msrIe;
      nextBip = msrBip;
      nextBe  = msrBe;
      case (bus.sel)
         selAdd: begin
            if (!bus.opcode[2])
               nextC = addCarry;
         end
         selShift: nextC = shiftCarry;
         selMove: begin
            if (isMts) begin
               nextC   = bus.opA[2];
               nextIe  = bus.opA[1];
               nextBip = bus.opA[3];
               nextBe  = bus.opA[0];
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         exValid <= 1'b0;
         msrC    <= 1'b0;
         msrIe   <= 1'b0;
         msrBip  <= 1'b0;
         msrBe   <= 1'b0;
      end else begin
         exValid <= bus.valid;
         if (bus.valid) begin
            msrC   <= nextC;
            msrIe  <= nextIe;
            msrBip <= nextBip;
            msrBe  <= nextBe;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (bus.valid) begin
         exResult    <= result;
         exRd        <= bus.rd;
         exSel       <= bus.sel;
         exAddrLow   <= {bus.opcode[1:0], addRes[1:0]};
         exStoreData <= bus.storeData;
      end
   end

endmodule

`default_nettype wire

/* logic/memLane.sv */
`timescale 1ns/1ps
`default_nettype none

module memLane import mbPkg::*; (
   input  logic       gclk,
   input  logic       rstN,
   input  logic       exValid,
   input  dataWord    exResult,
   input  regAddr     exRd,
   input  aluSel      exSel,
   input  logic [3:0] exAddrLow,
   input  dataWord    exStoreData,
   output logic       wbValid,
   output regAddr     wbRd,
   output dataWord    wbData,
   output logic       storeValid,
   output dataWord    storeAddr,
   output logic [3:0] storeSel,
   output dataWord    storeData
);

   logic [3:0] laneSel;
   dataWord    laneData;
   logic       isStore;

   assign isStore = (exSel == selStore);

   // Big-endian lanes, byte 0 sits in bits 31:24
   always_comb begin
      case (exAddrLow[3:2])
         2'b00: begin
            laneSel  = 4'b1000 >> exAddrLow[1:0];
            laneData = {4{exStoreData[7:0]}};
         end
         2'b01: begin
            laneSel  = exAddrLow[1] ? 4'h3 : 4'hC;
            laneData = {2{exStoreData[15:0]}};
         end
         2'b10: begin
            laneSel  = 4'hF;
            laneData = exStoreData;
         end
         default: begin
            laneSel  = 4'h0;
            laneData = exStoreData;
         end
      endcase
   end

   always_ff @(posedge gclk or negedge rstN) begin
      if (!rstN) begin
         wbValid    <= 1'b0;
         storeValid <= 1'b0;
      end else begin
         wbValid    <= exValid && !isStore;
         storeValid <= exValid && isStore;
      end
   end

   always_ff @(posedge gclk) begin
      if (exValid) begin
         wbRd      <= exRd;
         wbData    <= exResult;
         storeAddr <= {exResult[31:2], 2'b00}; // Word aligned
         storeSel  <= laneSel;
         storeData <= laneData;
      end
   end

endmodule

`default_nettype wire

/* logic/mbExecTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mbExecTop import mbPkg::*; #(
   parameter bit barrelShift = 1'b1
) (
   input  logic       gclk,
   input  logic       rstN,
   input  instWord    instr,
   input  logic       instrValid,
   output logic       resultValid,
   output regAddr     resultReg,
   output dataWord    resultData,
   output logic       storeValid,
   output dataWord    storeAddr,
   output logic [3:0] storeSel,
   output dataWord    storeData,
   output logic       msrC,
   output logic       msrIe
);

   execBus     exBus ();

   logic       exValid;
   dataWord    exResult;
   regAddr     exRd;
   aluSel      exSel;
   logic [3:0] exAddrLow;
   dataWord    exStoreData;

   // Write-back doubles as the result port
   instDecode uDecode (
      .gclk       (gclk),
      .rstN       (rstN),
      .instr      (instr),
      .instrValid (instrValid),
      .wbValid    (resultValid),
      .wbRd       (resultReg),
      .wbData     (resultData),
      .exValid    (exValid),
      .exRd       (exRd),
      .exSel      (exSel),
      .exResult   (exResult),
      .bus        (exBus.dec)
   );

   execUnit #(
      .barrelShift (barrelShift)
   ) uExec (
      .gclk        (gclk),
      .rstN        (rstN),
      .bus         (exBus.exe),
      .exValid     (exValid),
      .exResult    (exResult),
      .exRd        (exRd),
      .exSel       (exSel),
      .exAddrLow   (exAddrLow),
      .exStoreData (exStoreData),
      .msrC        (msrC),
      .msrIe       (msrIe)
   );

   memLane uMem (
      .gclk        (gclk),
      .rstN        (rstN),
      .exValid     (exValid),
      .exResult    (exResult),
      .exRd        (exRd),
      .exSel       (exSel),
      .exAddrLow   (exAddrLow),
      .exStoreData (exStoreData),
      .wbValid     (resultValid),
      .wbRd        (resultReg),
      .wbData      (resultData),
      .storeValid  (storeValid),
      .storeAddr   (storeAddr),
      .storeSel    (storeSel),
      .storeData   (storeData)
   );

endmodule

`default_nettype wire

/* include/mbExecRef.svh */
`ifndef MBEXECREF_SVH
`define MBEXECREF_SVH

// One expected output, a register result or a store
typedef struct packed {
   logic       isStore;
   regAddr     rd;
   dataWord    data;
   dataWord    addr;
   logic [3:0] sel;
} expEntry;

dataWord    refRegs [32];
logic       refC;
logic       refIe;
logic       refBip;
logic       refBe;
expEntry    expQ [$];
logic [1:0] expMsrQ [$];   // {C, IE} after each instruction

function automatic void resetRef();
   for (int k = 0; k < 32; k++)
      refRegs[k] = '0;
   {refC, refIe, refBip, refBe} = 4'd0;
endfunction

function automatic dataWord readReg(input regAddr r);
   return (r == '0) ? '0 : refRegs[r];
endfunction

// Second operand, sign-extended immediate when opcode bit 3 is set
function automatic dataWord operandB(input instWord i);
   if (i.rForm.opcode[3])
      return {{16{i.iForm.imm[15]}}, i.iForm.imm};
   return readReg(i.rForm.rb);
endfunction

function automatic void writeResult(input regAddr rd, input dataWord v);
   if (rd != '0)
      refRegs[rd] = v;
   expQ.push_back({1'b0, rd, v, 32'd0, 4'd0});
endfunction

// Reverse subtract is b + ~a + 1, carry forms take C instead of the 1
function automatic void stepArith(input instWord i);
   dataWord     a;
   logic        cin;
   logic [32:0] sum;
   a   = readReg(i.rForm.ra);
   cin = i.rForm.opcode[1] ? refC : i.rForm.opcode[0];
   if (i.rForm.opcode[0])
      a = ~a;
   sum = {1'b0, a} + {1'b0, operandB(i)} + 33'(cin);
   if (!i.rForm.opcode[2])
      refC = sum[32];   // Keep-carry forms leave C alone
   writeResult(i.rForm.rd, sum[31:0]);
endfunction

function automatic void stepLogic(input instWord i);
   dataWord a;
   dataWord b;
   a = readReg(i.rForm.ra);
   b = operandB(i);
   case (i.rForm.opcode[1:0])
      2'b00:   writeResult(i.rForm.rd, a | b);
      2'b01:   writeResult(i.rForm.rd, a & b);
      2'b10:   writeResult(i.rForm.rd, a ^ b);
      default: writeResult(i.rForm.rd, a & ~b);
   endcase
endfunction

function automatic void stepShift(input instWord i);
   dataWord a;
   dataWord v;
   a = readReg(i.rForm.ra);
   case (i.iForm.imm[6:5])
      2'b00:   v = {a[31], a[31:1]};
      2'b01:   v = {refC, a[31:1]};
      2'b10:   v = {1'b0, a[31:1]};
      default: v = i.iForm.imm[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
   endcase
   if (i.iForm.imm[6:5] != 2'b11)
      refC = a[0];   // Bit shifted out
   writeResult(i.rForm.rd, v);
endfunction

function automatic void stepMove(input instWord i);
   dataWord a;
   dataWord v;
   a = readReg(i.rForm.ra);
   if (i.iForm.imm[14]) begin
      refC   = a[2];
      refIe  = a[1];
      refBip = a[3];
      refBe  = a[0];
      writeResult(i.rForm.rd, a);
   end else begin
      v       = '0;
      v[31]   = refC;
      v[15:8] = msrVersion;
      v[3]    = refBip;
      v[2]    = refC;
      v[1]    = refIe;
      v[0]    = refBe;
      writeResult(i.rForm.rd, v);
   end
endfunction

function automatic void stepBarrel(input instWord i);
   dataWord a;
   dataWord b;
   a = readReg(i.rForm.ra);
   b = operandB(i);
   case (i.iForm.imm[10:9])
      2'b00:   writeResult(i.rForm.rd, a >> b[4:0]);
      2'b01:   writeResult(i.rForm.rd, dataWord'($signed(a) >>> b[4:0]));
      2'b10:   writeResult(i.rForm.rd, a << b[4:0]);
      default: writeResult(i.rForm.rd, '0);
   endcase
endfunction

// Big-endian lanes, offset 0 is the top byte
function automatic void stepStore(input instWord i);
   dataWord    a;
   dataWord    d;
   logic [3:0] s;
   a = readReg(i.rForm.ra) + operandB(i);
   d = readReg(i.rForm.rd);
   s = 4'hF;
   if (i.rForm.opcode[1:0] == 2'b00) begin
      s            = 4'd0;
      s[3 - a[1:0]] = 1'b1;
      d            = {4{d[7:0]}};
   end else if (i.rForm.opcode[1:0] == 2'b01) begin
      s = a[1] ? 4'h3 : 4'hC;
      d = {2{d[15:0]}};
   end
   expQ.push_back({1'b1, 5'd0, d, {a[31:2], 2'b00}, s});
endfunction

function automatic void refStep(input instWord i);
   case (i.rForm.opcode & 6'h37)
      opOr, opAnd, opXor, opAndn: stepLogic(i);
      opShift:                    stepShift(i);
      opMsr:                      stepMove(i);
      opBarrel:                   stepBarrel(i);
      opSb, opSh, opSw:           stepStore(i);
      default:                    stepArith(i);
   endcase
   expMsrQ.push_back({refC, refIe});
endfunction

`endif

/* dv/mbExecTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mbExecTb import mbPkg::*; ();

   localparam int resetCycles = 10;
   localparam int numTests    = 6;
   // Seed 21, arith 40, logic 32, shift 24, msr 16, barrel 24, store 12
   localparam int totalInstr  = 169;
   localparam int cycleLimit  = resetCycles + totalInstr + 5 * numTests + 20;

   logic        gclk;
   logic        rstN;
   instWord     instr;
   logic        instrValid;
   logic        resultValid;
   regAddr      resultReg;
   dataWord     resultData;
   logic        storeValid;
   dataWord     storeAddr;
   logic [3:0]  storeSel;
   dataWord     storeData;
   logic        msrC;
   logic        msrIe;

   int          checkCount;
   int          errCount;
   int          lastChecks;
   int          lastErrs;
   int          cycleCount;
   logic [1:0]  issuePipe;   // Issue history for the status check at n+2

   `include "mbExecRef.svh"

   mbExecTop #(
      .barrelShift (1'b1)
   ) dut (
      .gclk        (gclk),
      .rstN        (rstN),
      .instr       (instr),
      .instrValid  (instrValid),
      .resultValid (resultValid),
      .resultReg   (resultReg),
      .resultData  (resultData),
      .storeValid  (storeValid),
      .storeAddr   (storeAddr),
      .storeSel    (storeSel),
      .storeData   (storeData),
      .msrC        (msrC),
      .msrIe       (msrIe)
   );

   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   task automatic checkResult(input regAddr expRd, input dataWord expData);
      checkCount++;
      if (!resultValid) begin
         errCount++;
         $display("A store came out where a register result was expected");
      end else if (resultReg !== expRd || resultData !== expData) begin
         errCount++;
         $display("[ERROR] resultReg exp %h got %h, resultData exp %h got %h",
                  expRd, resultReg, expData, resultData);
      end
   endtask

   task automatic checkStore(input dataWord expAddr, input logic [3:0] expSel,
                             input dataWord expData);
      checkCount++;
      if (!storeValid) begin
         errCount++;
         $display("A register result came out where a store was expected");
      end else if (storeAddr !== expAddr || storeSel !== expSel || storeData !== expData) begin
         errCount++;
         $display("[ERROR] storeAddr exp %h got %h, storeSel exp %h got %h, %s %h got %h",
                  expAddr, storeAddr, expSel, storeSel, "storeData exp", expData, storeData);
      end
   endtask

   task automatic checkMsr(input logic expC, input logic expIe);
      checkCount++;
      if (msrC !== expC || msrIe !== expIe) begin
         errCount++;
         $display("[ERROR] msrC exp %h got %h, msrIe exp %h got %h", expC, msrC, expIe, msrIe);
      end
   endtask

   // Outputs sampled mid-cycle on the falling edge
   always @(negedge gclk) begin : compare
      expEntry    e;
      logic [1:0] m;
      if (resultValid || storeValid) begin
         if (expQ.size() == 0) begin
            errCount++;
            $display("An output appeared with no instruction outstanding");
         end else begin
            e = expQ.pop_front();
            if (e.isStore)
               checkStore(e.addr, e.sel, e.data);
            else
               checkResult(e.rd, e.data);
         end
      end
      if (issuePipe[1]) begin
         if (expMsrQ.size() == 0) begin
            errCount++;
            $display("Status check due with no expected status queued");
         end else begin
            m = expMsrQ.pop_front();
            checkMsr(m[1], m[0]);
         end
      end
      issuePipe = {issuePipe[0], instrValid};
   end

   always @(posedge gclk) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("Timeout after %0d cycles, outputs still pending", cycleCount);
         $display("sim failed");
         $finish;
      end
   end

   function automatic instWord mkInst(input logic [5:0] op, input regAddr rd,
                                      input regAddr ra, input logic [15:0] low);
      return {op, rd, ra, low};
   endfunction

   // Small register set keeps dependencies dense
   function automatic regAddr pickReg(input logic allowZero);
      logic [31:0] r;
      r = $urandom();
      if (allowZero)
         return regAddr'(r[2:0]);
      return regAddr'(r % 7 + 1);
   endfunction

   task automatic issue(input instWord i);
      refStep(i);
      instr      = i;
      instrValid = 1'b1;
      @(posedge gclk);
      #1;
   endtask

   task automatic finishTest(input string name);
      instrValid = 1'b0;
      while (expQ.size() != 0 || expMsrQ.size() != 0)
         @(posedge gclk);
      #1;
      $display("%-8s %0d checks, %0d errors", name, checkCount - lastChecks, errCount - lastErrs);
      lastChecks = checkCount;
      lastErrs   = errCount;
   endtask

   // Full 32-bit values in r1 to r7
   task automatic seedRegs();
      logic [31:0] r;
      for (int k = 1; k < 8; k++) begin
         r = $urandom();
         issue(mkInst(opAddi, regAddr'(k), 5'd0, r[31:16]));
         issue(mkInst(opBarrel | 6'h08, regAddr'(k), regAddr'(k), 16'h0410)); // Left by 16
         issue(mkInst(opAddi, regAddr'(k), regAddr'(k), r[15:0]));
      end
   endtask

   // Group 00 is the add family, 10 the logic family
   task automatic runMixed(input logic [1:0] group, input int count, input string name);
      logic [31:0] r;
      logic [15:0] low;
      for (int k = 0; k < count; k++) begin
         r   = $urandom();
         low = r[2] ? r[31:16] : {pickReg(1'b1), 11'd0};
         issue(mkInst({group, r[2], 1'b0, r[1:0]}, pickReg(1'b0), pickReg(1'b1), low));
      end
      finishTest(name);
   endtask

   task automatic runShift();
      logic [31:0] r;
      for (int k = 0; k < 24; k++) begin
         r = $urandom();
         issue(mkInst(opShift, pickReg(1'b0), pickReg(1'b1), {9'd0, r[1:0], 4'd0, r[2]}));
      end
      finishTest("shift");
   endtask

   task automatic runMsr();
      for (int k = 0; k < 8; k++) begin
         issue(mkInst(opMsr, 5'd0, pickReg(1'b0), 16'h4000));   // Move to status
         issue(mkInst(opMsr, pickReg(1'b0), 5'd0, 16'h0000));   // Read it back
      end
      finishTest("msr");
   endtask

   task automatic runBarrel();
      logic [31:0] r;
      logic [1:0]  dir;
      for (int k = 0; k < 24; k++) begin
         r   = $urandom();
         dir = 2'(k % 3);
         if (k % 2 == 0)
            issue(mkInst(opBarrel, pickReg(1'b0), pickReg(1'b1), {pickReg(1'b1), dir, 9'd0}));
         else
            issue(mkInst(opBarrel | 6'h08, pickReg(1'b0), pickReg(1'b1),
                         {5'd0, dir, 4'd0, r[4:0]}));
      end
      finishTest("barrel");
   endtask

   // Immediate chosen so the address lands on each offset
   task automatic runStore();
      logic [31:0] r;
      regAddr      base;
      logic [1:0]  lowBits;
      for (int sz = 0; sz < 3; sz++) begin
         for (int off = 0; off < 4; off++) begin
            r       = $urandom();
            base    = pickReg(1'b0);
            lowBits = 2'(off) - refRegs[base][1:0];
            issue(mkInst({4'b1110, 2'(sz)}, pickReg(1'b1), base, {r[15:2], lowBits}));
         end
      end
      finishTest("store");
   endtask

   initial begin
      void'($urandom(82));
      checkCount = 0;
      errCount   = 0;
      lastChecks = 0;
      lastErrs   = 0;
      cycleCount = 0;
      issuePipe  = '0;
      instr      = '0;
      instrValid = 1'b0;
      rstN       = 1'b0;
      resetRef();
      repeat (resetCycles) @(posedge gclk);
      #1;
      rstN = 1'b1;
      seedRegs();
      runMixed(2'b00, 40, "arith");
      runMixed(2'b10, 32, "logic");
      runShift();
      runMsr();
      runBarrel();
      runStore();
      $display("%0d tests, %0d checks, %0d errors", numTests, checkCount, errCount);
      if (errCount == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

/* mbExec.f */
+incdir+include
logic/mbPkg.sv
logic/execBus.sv
logic/instDecode.sv
logic/execUnit.sv
logic/memLane.sv
logic/mbExecTop.sv
dv/mbExecTb.sv

/* runSim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f mbExec.f --top-module mbExecTb -o mbExecSim
./obj_dir/mbExecSim > sim.log
cat sim.log

if grep -q "^sim passed$" sim.log; then
   exit 0
fi
echo "Simulation reported failure, see sim.log"
exit 1
